//--- common/icache_pkg.sv
// Geometry, encodings and payload types shared by the instruction cache
// Every cache module and the testbench import this package
package icache_pkg;

  localparam int addr_bits   = 32;                     // Fetch byte address width
  localparam int word_bits   = 32;                     // Instruction and bus data width
  localparam int line_words  = 4;
  localparam int line_bits   = line_words * word_bits; // One full line as stored in the data memory
  localparam int sets        = 64;
  localparam int index_bits  = 6;
  localparam int offset_bits = 2;                      // Word select inside a line
  localparam int tag_bits    = 22;

  // Bit positions of the address fields
  localparam int index_lsb = 4;                        // Bits 1:0 are the byte within a word
  localparam int tag_lsb   = index_lsb + index_bits;

  // AXI protection bits for an unprivileged secure instruction access
  localparam logic [2:0] arprot_insn = 3'b100;

  typedef enum logic [1:0] {
    idle,
    send_addr,                                         // AR valid until the slave takes it
    wait_data,                                         // R ready until the beat arrives
    write_line                                         // Line and tag written in this cycle
  } refill_state_e;

  typedef enum logic {
    status_ok,
    status_bus_error
  } fetch_status_e;

  typedef struct packed {
    logic [addr_bits-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [word_bits-1:0] data;
    fetch_status_e        status;
  } fetch_resp_t;

  // One in-flight request in the lookup pipeline
  typedef struct packed {
    logic [addr_bits-1:0] addr;
    logic                 valid;
  } lookup_stage_t;

  typedef struct packed {
    logic [tag_bits-1:0]   tag;
    logic [index_bits-1:0] index;
  } miss_req_t;

  typedef struct packed {
    logic [addr_bits-1:0] araddr;
    logic [2:0]           arprot;
  } axil_ar_t;

  typedef struct packed {
    logic [word_bits-1:0] rdata;
    logic [1:0]           rresp;                       // Nonzero means the slave reported an error
  } axil_r_t;

endpackage

//--- icache/inst_cache_memory.sv
// Line data memory with one write port and one registered read port
// A write to the address being read shows up on doutb in the same cycle as a read would
module inst_cache_memory #(
  parameter int ram_width = 128,                 // Bits per entry
  parameter int ram_depth = 64                   // Number of entries
) (
  input  logic                         clka,
  input  logic [$clog2(ram_depth)-1:0] addra,    // Write address
  input  logic [$clog2(ram_depth)-1:0] addrb,    // Read address
  input  logic [ram_width-1:0]         dina,
  input  logic                         wea,
  output logic [ram_width-1:0]         doutb
);

  // Starts all zero so an unwritten entry reads as a known value
  logic [ram_width-1:0] mem [ram_depth] = '{default: '0};
  logic [ram_width-1:0] wr_data_q;               // Copy of the last write data for forwarding
  logic [ram_width-1:0] rd_data_q;
  logic                 fwd_q;                   // Last cycle wrote the entry that was read

  always_ff @(posedge clka) begin
    if (wea) begin
      mem[addra] <= dina;
    end
    wr_data_q <= dina;
    rd_data_q <= mem[addrb];                     // Old contents on a collision
    fwd_q     <= wea && (addra == addrb);
  end

  // Write-first behaviour on a same-address collision
  assign doutb = fwd_q ? wr_data_q : rd_data_q;

  // A write with an unknown address would corrupt an arbitrary line
  // and break the forwarding compare on the read side
  a_addr_known: assert property (
    @(posedge clka) wea |-> !$isunknown(addra) && !$isunknown(addrb)
  );

endmodule

//--- icache/icache_tag_store.sv
// Tag array and valid bits of the cache, read one cycle after the index
// Forwards a same-index write so tags stay aligned with the line memory
module icache_tag_store
  import icache_pkg::*;
(
  input  logic                  clka,
  input  logic                  rst_n,
  input  logic                  flush,           // Invalidates every line at the next edge
  input  logic [index_bits-1:0] rd_index,
  output logic [tag_bits-1:0]   rd_tag,
  output logic                  rd_valid,
  input  logic                  wr_en,
  input  logic [index_bits-1:0] wr_index,
  input  logic [tag_bits-1:0]   wr_tag,
  input  logic                  wr_valid         // Low after a failed refill
);

  logic [tag_bits-1:0] tags [sets];
  logic [sets-1:0]     valid_q;                  // One valid flop per set
  logic                collide;

  // Write hits the entry being read in this cycle
  assign collide = wr_en && (wr_index == rd_index);

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (flush) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_index] <= wr_valid;
    end
  end

  always_ff @(posedge clka) begin
    if (wr_en) begin
      tags[wr_index] <= wr_tag;
    end
  end

  // Registered read with the same write-first rule as the data memory
  always_ff @(posedge clka) begin
    rd_tag <= collide ? wr_tag : tags[rd_index];
  end

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else if (flush) begin
      rd_valid <= 1'b0;                          // A flushed line must not hit on the next compare
    end else begin
      rd_valid <= collide ? wr_valid : valid_q[rd_index];
    end
  end

  // Flush only comes while the refill engine is idle,
  // so it never races a line write
  a_no_flush_on_write: assert property (
    @(posedge clka) disable iff (!rst_n) !(wr_en && flush)
  );

endmodule

//--- icache/icache_lookup.sv
// Two-stage fetch pipeline: index the stores, then compare the tag and pick the word
// Freezes on a miss and hands the line address to the refill engine
module icache_lookup
  import icache_pkg::*;
(
  input  logic                  clka,
  input  logic                  rst_n,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  fetch_req_t            req,
  output logic                  resp_valid,
  input  logic                  resp_ready,
  output fetch_resp_t           resp,
  output logic [index_bits-1:0] rd_index,
  input  logic [tag_bits-1:0]   rd_tag,
  input  logic                  rd_valid,
  input  logic [line_bits-1:0]  line_data,
  output logic                  miss_valid,
  output miss_req_t             miss,
  input  logic                  refill_done,
  input  fetch_status_e         refill_status
);

  lookup_stage_t        s1_q;                    // Request whose index goes to the stores
  lookup_stage_t        s2_q;                    // Request lined up with the store outputs
  logic                 replay_q;                // One cycle to re-read the index after a refill
  logic                 replay_err_q;            // The refill failed so no re-read is needed
  logic                 stall_out, busy, hit, miss_now, s2_fire;
  logic [word_bits-1:0] sel_word;

  assign stall_out = resp_valid && !resp_ready;  // Output register is held
  assign busy      = miss_valid || replay_q;
  assign hit       = s2_q.valid && rd_valid && (rd_tag == s2_q.addr[addr_bits-1:tag_lsb]);
  assign miss_now  = s2_q.valid && !hit && !busy && !stall_out;
  // Stage 2 empties on a hit, when it holds nothing, or with the error reply
  assign s2_fire   = !stall_out && (busy ? (replay_q && replay_err_q) : (!s2_q.valid || hit));
  assign req_ready = s2_fire;
  // While frozen the stores keep reading the stage 2 index so their outputs stay aligned
  assign rd_index  = s2_fire ? s1_q.addr[tag_lsb-1:index_lsb] : s2_q.addr[tag_lsb-1:index_lsb];
  assign sel_word  = line_data[s2_q.addr[index_lsb-1 -: offset_bits] * word_bits +: word_bits];

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      s1_q <= '0;
      s2_q <= '0;
    end else if (s2_fire) begin
      s1_q <= '{addr: req.addr, valid: req_valid};
      s2_q <= s1_q;
    end
  end

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (s2_fire) begin
      resp_valid <= s2_q.valid;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clka) begin
    if (s2_fire && s2_q.valid) begin
      // A failed refill returns the last beat, found in the top word of the line
      resp <= replay_q ? '{data: line_data[line_bits-1 -: word_bits], status: status_bus_error}
                       : '{data: sel_word, status: status_ok};
    end
  end

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      miss_valid   <= 1'b0;
      replay_q     <= 1'b0;
      replay_err_q <= 1'b0;
    end else if (refill_done) begin
      miss_valid   <= 1'b0;
      replay_q     <= 1'b1;
      replay_err_q <= (refill_status == status_bus_error);
    end else begin
      replay_q <= 1'b0;
      if (miss_now) begin
        miss_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clka) begin
    if (miss_now) begin
      miss <= '{tag: s2_q.addr[addr_bits-1:tag_lsb], index: s2_q.addr[tag_lsb-1:index_lsb]};
    end
  end

  a_resp_stable: assert property (
    @(posedge clka) disable iff (!rst_n)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp)
  );

  // A miss is only raised once the output register has drained
  a_miss_no_resp: assert property (
    @(posedge clka) disable iff (!rst_n) miss_valid |-> !resp_valid
  );

endmodule

//--- icache/icache_refill.sv
// Refill engine that reads one cache line as four AXI4-Lite single-word reads
// Writes the gathered line and its tag, then pulses refill_done to the lookup pipeline
module icache_refill
  import icache_pkg::*;
(
  input  logic                  clka,
  input  logic                  rst_n,
  input  logic                  miss_valid,
  input  miss_req_t             miss,
  output logic                  refill_done,     // One-cycle pulse in write_line
  output fetch_status_e         refill_status,
  output logic                  arvalid,
  input  logic                  arready,
  output axil_ar_t              ar,
  input  logic                  rvalid,
  output logic                  rready,
  input  axil_r_t               r,
  output logic                  wea,
  output logic [index_bits-1:0] addra,
  output logic [line_bits-1:0]  dina,
  output logic                  tag_wr,
  output logic [tag_bits-1:0]   tag,
  output logic                  tag_valid
);

  refill_state_e          state_q;
  miss_req_t              line_q;                // Line being fetched
  logic [offset_bits-1:0] beat_q;                // Word number of the current AR/R pair
  logic [line_bits-1:0]   buf_q;                 // Gathered words, word 0 ends up lowest
  logic                   err_q;                 // Sticky over the four beats

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= idle;
      beat_q  <= '0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        idle: begin
          if (miss_valid) begin
            state_q <= send_addr;
            beat_q  <= '0;                       // Always start at the line base
            err_q   <= 1'b0;
          end
        end
        send_addr: begin
          if (arready) begin
            state_q <= wait_data;
          end
        end
        wait_data: begin
          if (rvalid) begin
            err_q <= err_q || (r.rresp != 2'b00);
            // Every beat is consumed even after an error
            if (beat_q == offset_bits'(line_words - 1)) begin
              state_q <= write_line;
            end else begin
              beat_q  <= beat_q + 1'b1;
              state_q <= send_addr;
            end
          end
        end
        write_line: state_q <= idle;
        default:    state_q <= idle;
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (state_q == idle && miss_valid) begin
      line_q <= miss;
    end
    if (state_q == wait_data && rvalid) begin
      buf_q <= {r.rdata, buf_q[line_bits-1:word_bits]}; // Shift down, newest word on top
    end
  end

  // Only one read outstanding, the address comes from registers only
  assign arvalid = (state_q == send_addr);
  assign ar      = '{araddr: {line_q, beat_q, 2'b00}, arprot: arprot_insn};
  assign rready  = (state_q == wait_data);

  assign wea           = (state_q == write_line);
  assign tag_wr        = (state_q == write_line);
  assign refill_done   = (state_q == write_line);
  assign addra         = line_q.index;
  assign dina          = buf_q;
  assign tag           = line_q.tag;
  assign tag_valid     = !err_q;                 // A failed line stays invalid
  assign refill_status = err_q ? status_bus_error : status_ok;

  // AXI requires the request to hold until the slave accepts it
  a_ar_stable: assert property (
    @(posedge clka) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(ar)
  );

endmodule

//--- rtl/icache_top.sv
// Direct-mapped instruction cache between a fetch unit and an AXI4-Lite memory
// Wires the lookup pipeline to the tag store, the line memory and the refill engine
module icache_top
  import icache_pkg::*;
(
  input  logic          clka,
  input  logic          rst_n,
  input  logic          flush,        // Clears every valid bit
  input  logic          req_valid,
  output logic          req_ready,
  input  fetch_req_t    req,
  output logic          resp_valid,
  input  logic          resp_ready,
  output fetch_resp_t   resp,
  output logic          arvalid,
  input  logic          arready,
  output axil_ar_t      ar,
  input  logic          rvalid,
  output logic          rready,
  input  axil_r_t       r
);

  logic [index_bits-1:0] rd_index;    // Shared read index of both stores
  logic [tag_bits-1:0]   rd_tag;
  logic                  rd_valid;
  logic [line_bits-1:0]  line_data;
  logic                  miss_valid;
  miss_req_t             miss;
  logic                  refill_done;
  fetch_status_e         refill_status;
  logic                  wea;         // Line write from the refill engine
  logic [index_bits-1:0] addra;
  logic [line_bits-1:0]  dina;
  logic                  tag_wr;
  logic [tag_bits-1:0]   tag;
  logic                  tag_valid;

  icache_lookup u_lookup (
    .clka, .rst_n, .req_valid, .req_ready, .req, .resp_valid, .resp_ready, .resp,
    .rd_index, .rd_tag, .rd_valid, .line_data, .miss_valid, .miss, .refill_done, .refill_status
  );

  icache_tag_store u_tag_store (
    .clka, .rst_n, .flush, .rd_index, .rd_tag, .rd_valid,
    .wr_en(tag_wr), .wr_index(addra), .wr_tag(tag), .wr_valid(tag_valid)
  );

  inst_cache_memory #(.ram_width(line_bits), .ram_depth(sets)) u_data_mem (
    .clka, .addra, .addrb(rd_index), .dina, .wea, .doutb(line_data)
  );

  icache_refill u_refill (
    .clka, .rst_n, .miss_valid, .miss, .refill_done, .refill_status,
    .arvalid, .arready, .ar, .rvalid, .rready, .r,
    .wea, .addra, .dina, .tag_wr, .tag, .tag_valid
  );

endmodule

//--- test/axil_mem_model.sv
// AXI4-Lite read-only slave for the cache testbench, with random handshake delays
// Read data is the inverted word address, and one marked line answers with a slave error
module axil_mem_model
  import icache_pkg::*;
#(
  parameter logic [31:0] err_line = 32'h0000_f000   // Base of the line that fails every read
) (
  input  logic     clka,
  input  logic     rst_n,
  input  logic     arvalid,
  output logic     arready,
  input  axil_ar_t ar,
  output logic     rvalid,
  input  logic     rready,
  output axil_r_t  r
);

  logic        have_addr;                         // Address taken and read data still owed
  logic [31:0] addr_q;
  int unsigned ar_wait;                           // Idle cycles left before arready
  int unsigned r_wait;                            // Idle cycles left before rvalid

  always @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      arready   <= 1'b0;
      rvalid    <= 1'b0;
      have_addr <= 1'b0;
      addr_q    <= '0;
      ar_wait   <= 0;
      r_wait    <= 0;
      r         <= '0;
    end else begin
      arready <= 1'b0;                            // Ready is a one-cycle pulse per address
      if (arvalid && arready) begin
        have_addr <= 1'b1;
        addr_q    <= ar.araddr;
        r_wait    <= $urandom % 4;
        ar_wait   <= $urandom % 4;                // Delay for the next address
      end else if (arvalid && !have_addr) begin
        if (ar_wait == 0) begin
          arready <= 1'b1;
        end else begin
          ar_wait <= ar_wait - 1;
        end
      end
      if (rvalid && rready) begin
        rvalid    <= 1'b0;
        have_addr <= 1'b0;
      end else if (have_addr && !rvalid) begin
        if (r_wait == 0) begin
          rvalid <= 1'b1;
          // SLVERR for the marked line, data still follows the address rule
          r <= '{rdata: ~addr_q, rresp: (addr_q[31:4] == err_line[31:4]) ? 2'b10 : 2'b00};
        end else begin
          r_wait <= r_wait - 1;
        end
      end
    end
  end

endmodule

//--- test/icache_tb.sv
// Testbench for the instruction cache: directed misses, hits, eviction, flush and bus errors
// Ends with a random back-pressure run checked against a queue of accepted addresses
module icache_tb
  import icache_pkg::*;
();

  localparam int          clk_period      = 40;
  localparam int          n_hits          = 8;     // Back-to-back hit requests
  localparam int          n_random        = 40;    // Requests under random back-pressure
  localparam int          n_requests      = 10 + n_hits + n_random;
  localparam int          watchdog_cycles = 200 * n_requests;
  localparam logic [31:0] err_line        = 32'h0000_f000;

  logic        clka, rst_n, flush, req_valid, req_ready, resp_valid, resp_ready;
  logic        arvalid, arready, rvalid, rready;
  fetch_req_t  req;
  fetch_resp_t resp, exp_resp;
  axil_ar_t    ar;
  axil_r_t     r;
  logic        bp_mode, hit_phase;                 // Random resp_ready, hit latency checks
  logic [2:0]  accepted_d = '0;                    // Request handshakes of the last three edges
  logic [1:0]  ar_beat = '0;                       // Word number of the next AR in a fill
  logic [31:0] fill_base = '0;
  logic [31:0] exp_addr;
  int          ar_total = 0;
  logic        got_resp, sb_was_empty;
  logic [31:0] sb_q[$];                            // Accepted addresses in acceptance order

  icache_top u_icache_top (.*);
  axil_mem_model #(.err_line(err_line)) u_mem_model (.*);

  task automatic end_with_errors();
    $display("Finished with errors");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic fail_check(input string msg);
    $display("FAILED at time %0t: %s", $time, msg);
    end_with_errors();
  endtask

  // Reference response from the memory rule
  // A failed line returns the data of its last beat
  function automatic fetch_resp_t expected_resp(input logic [31:0] addr);
    fetch_resp_t exp;
    if (addr[31:4] == err_line[31:4]) begin
      exp = '{data: ~{addr[31:4], 4'hc}, status: status_bus_error};
    end else begin
      exp = '{data: ~addr, status: status_ok};
    end
    return exp;
  endfunction

  function automatic logic [31:0] pick_addr(input bit hit_lines);
    if (hit_lines) begin
      return 32'h0000_0100 + (($urandom % 8) << 2);  // Lines 0x100 and 0x110, both filled
    end
    // Two tags over eight indexes so lines get evicted and refetched
    return 32'h0000_2000 + (($urandom % 2) << 10) + (($urandom % 8) << 4) + (($urandom % 4) << 2);
  endfunction

  task automatic wait_drained();
    @(negedge clka);
    while (sb_q.size() != 0) begin
      @(negedge clka);
    end
    @(posedge clka);
  endtask

  task automatic fetch_one(input logic [31:0] addr, input int exp_ars);
    int ars_before;
    ars_before = ar_total;
    req_valid <= 1'b1;
    req       <= '{addr: addr};
    @(posedge clka);
    while (!req_ready) begin
      @(posedge clka);
    end
    req_valid <= 1'b0;
    wait_drained();
    assert (ar_total - ars_before == exp_ars && (exp_ars == 0 || fill_base == {addr[31:4], 4'h0}))
      else fail_check($sformatf("fetch %h made %0d AR transfers, expected %0d", addr,
                                ar_total - ars_before, exp_ars));
  endtask

  task automatic fetch_stream(input int count, input bit hit_lines);
    for (int i = 0; i < count; i++) begin
      req_valid <= 1'b1;
      req       <= '{addr: pick_addr(hit_lines)};
      @(posedge clka);
      while (!req_ready) begin
        @(posedge clka);
      end
    end
    req_valid <= 1'b0;
    wait_drained();
  endtask

  task automatic pulse_flush();
    flush <= 1'b1;
    @(posedge clka);
    flush <= 1'b0;
    @(posedge clka);
  endtask

  initial begin
    clka = 1'b0;
    forever #(clk_period / 2) clka = ~clka;
  end

  always @(posedge clka) begin
    resp_ready <= bp_mode ? (($urandom % 3) != 0) : 1'b1;
    accepted_d <= {accepted_d[1:0], rst_n && req_valid && req_ready};
  end

  // Each response is matched against the oldest accepted address
  always @(posedge clka) begin
    got_resp     = rst_n && resp_valid && resp_ready;
    sb_was_empty = (sb_q.size() == 0);
    if (got_resp && !sb_was_empty) begin
      exp_addr = sb_q.pop_front();
      exp_resp = expected_resp(exp_addr);
    end
    if (rst_n && req_valid && req_ready) begin
      sb_q.push_back(req.addr);
    end
    if (got_resp) begin
      assert (!sb_was_empty && resp == exp_resp)
        else fail_check($sformatf("response %h status %0d for %h, expected %h status %0d",
                                  resp.data, resp.status, exp_addr, exp_resp.data, exp_resp.status));
    end
  end

  // Fills go out as ascending words from the line base, flagged as instruction reads
  always @(posedge clka) begin
    if (rst_n && arvalid && arready) begin
      ar_total <= ar_total + 1;
      ar_beat  <= ar_beat + 2'd1;
      if (ar_beat == 2'd0) begin
        fill_base <= {ar.araddr[31:4], 4'h0};
      end
      assert (ar.araddr[3:0] == {ar_beat, 2'b00} && ar.arprot[2] &&
              (ar_beat == 2'd0 || ar.araddr[31:4] == fill_base[31:4]))
        else fail_check($sformatf("AR address %h is out of order as beat %0d", ar.araddr, ar_beat));
    end
  end

  a_reset_state: assert property (
    @(posedge clka) $rose(rst_n) |-> !resp_valid && !arvalid && !rready && req_ready
  ) else fail_check("outputs are not idle after reset");

  // Accepted at one edge, visible after the second edge that follows
  a_hit_latency: assert property (
    @(posedge clka) disable iff (!rst_n) hit_phase && accepted_d[2] |-> resp_valid
  ) else fail_check("hit response was not two cycles after acceptance");

  a_hit_no_ar: assert property (
    @(posedge clka) disable iff (!rst_n) hit_phase |-> !arvalid
  ) else fail_check("AR request issued for a line that should hit");

  a_resp_held: assert property (
    @(posedge clka) disable iff (!rst_n) resp_valid && !resp_ready |=> resp_valid && $stable(resp)
  ) else fail_check("response changed while stalled");

  a_no_accept_stalled: assert property (
    @(posedge clka) disable iff (!rst_n) resp_valid && !resp_ready |-> !req_ready
  ) else fail_check("request accepted while the response was stalled");

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timed out: the run did not finish within %0d clock cycles", watchdog_cycles);
    end_with_errors();
  end

  initial begin
    void'($urandom(32'hf08e8fe6));
    rst_n      = 1'b0;
    flush      = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    resp_ready = 1'b1;
    bp_mode    = 1'b0;
    hit_phase  = 1'b0;
    repeat (2) @(posedge clka);
    rst_n <= 1'b1;
    repeat (2) @(posedge clka);
    fetch_one(32'h0000_0108, 4);                   // Cold miss fills line 0x100
    fetch_one(32'h0000_0110, 4);
    fetch_one(32'h0000_010c, 0);
    hit_phase <= 1'b1;
    fetch_stream(n_hits, 1'b1);
    hit_phase <= 1'b0;
    fetch_one(32'h0000_0504, 4);                   // Same index as 0x100 with another tag
    fetch_one(32'h0000_0100, 4);
    fetch_one(32'h0000_0104, 0);
    pulse_flush();
    fetch_one(32'h0000_0104, 4);
    fetch_one(32'h0000_0114, 4);                   // Flush dropped this line as well
    fetch_one(32'h0000_f004, 4);                   // Slave error keeps the line invalid
    fetch_one(32'h0000_f004, 4);
    bp_mode <= 1'b1;
    fetch_stream(n_random, 1'b0);
    bp_mode <= 1'b0;
    @(posedge clka);
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- src.f
common/icache_pkg.sv
icache/inst_cache_memory.sv
icache/icache_tag_store.sv
icache/icache_lookup.sv
icache/icache_refill.sv
rtl/icache_top.sv
test/axil_mem_model.sv
test/icache_tb.sv

//--- Makefile
# Verilator flow for the instruction cache testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
